// File: common/ccu_params.svh
//==========================================================================
// CCU build-time constants
// PE count, FIFO depths as address widths, APB register offsets
//==========================================================================
`ifndef CCU_PARAMS_SVH
`define CCU_PARAMS_SVH

// Number of PE blocks behind the controller
`define CCU_NUM_PEB     4

// FIFO address widths (depth is 2**AW)
`define CCU_CMD_AW      4
`define CCU_RES_AW      3

// APB address width and byte offsets of the register map
`define CCU_APB_AW      4
`define CCU_REG_CMD     4'h0
`define CCU_REG_CTRL    4'h4
`define CCU_REG_STATUS  4'h8
`define CCU_REG_RESULT  4'hC

`endif

// File: common/ccu_pkg.sv
//==========================================================================
// CCU shared types
// Command and result words, PE fields, accumulator, controller states
//==========================================================================
`include "ccu_params.svh"

package ccu_pkg;

    // Command word as written by the host
    // [31:30] PE index, [29:24] len, [23:16] reserved, [15:0] base
    typedef logic [31:0] cmd_t;

    // Result word popped by the host
    // [31:30] PE index, [29:0] sum
    typedef logic [31:0] result_t;

    // Accumulator, wraps modulo 2^30
    typedef logic [29:0] sum_t;

    // PE select, sized from the PE count
    typedef logic [$clog2(`CCU_NUM_PEB)-1:0] pe_idx_t;

    // Run length, 0 to 63 terms
    typedef logic [5:0] len_t;

    // First term of a run
    typedef logic [15:0] base_t;

    // Controller FSM
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } ccu_state_t;

endpackage

// File: common/pe_bus_if.sv
//==========================================================================
// Link between the CCU controller and the PE array
// Single issue channel plus per-PE busy / done / sum / ack vectors
//==========================================================================
`include "ccu_params.svh"

interface pe_bus_if;

    // Issue channel, one command per cycle at most
    logic                                       issue_valid;
    ccu_pkg::pe_idx_t                           issue_pe;
    ccu_pkg::base_t                             issue_base;
    ccu_pkg::len_t                              issue_len;

    // Per-PE handshake
    logic [`CCU_NUM_PEB-1:0]                    ack;
    logic [`CCU_NUM_PEB-1:0]                    busy;
    logic [`CCU_NUM_PEB-1:0]                    done;
    ccu_pkg::sum_t [`CCU_NUM_PEB-1:0]           sum;

    // Controller side
    modport ctrl (
        output issue_valid, issue_pe, issue_base, issue_len, ack,
        input  busy, done, sum
    );

    // PE array side
    modport pe (
        input  issue_valid, issue_pe, issue_base, issue_len, ack,
        output busy, done, sum
    );

endinterface

// File: hdl/sync_fifo.sv
//==========================================================================
// Synchronous FIFO
// Circular buffer, pointers one bit wider than the address
// Show-ahead read port, overflow and underflow ignored
//==========================================================================
module sync_fifo #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  logic              pop,
    input  logic [DATA_W-1:0] din,
    output logic [DATA_W-1:0] dout,
    output logic              empty,
    output logic              full
);

    localparam int DEPTH = 1 << ADDR_W;

    // Storage
    logic [DATA_W-1:0] mem [0:DEPTH-1];

    // Extra MSB tells a wrapped write pointer from an equal one
    logic [ADDR_W:0]   wr_ptr;
    logic [ADDR_W:0]   rd_ptr;

    logic              do_push;
    logic              do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // Qualified requests
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head of queue, no pop needed
    assign dout = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[ADDR_W-1:0]] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: hdl/apb_cfg_regs.sv
//==========================================================================
// APB register block of the CCU
// CMD push, CTRL start, STATUS readback, RESULT pop
// No wait states, error response on overflow and empty read
//==========================================================================
`include "ccu_params.svh"

module apb_cfg_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    // APB slave
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`CCU_APB_AW-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    // Command FIFO write side
    output logic                   cmd_push,
    output ccu_pkg::cmd_t          cmd_wdata,
    input  logic                   cmd_full,
    // Result FIFO read side
    output logic                   res_pop,
    input  ccu_pkg::result_t       res_rdata,
    input  logic                   res_empty,
    // Controller
    output logic                   start,
    input  logic                   busy,
    input  logic                   done
);

    logic wr_acc;
    logic rd_acc;
    logic start_req;

    // Access phase decode
    assign wr_acc = psel && penable && pwrite;
    assign rd_acc = psel && penable && !pwrite;

    assign pready = 1'b1;

    // Command push, dropped when the FIFO is full
    assign cmd_push  = wr_acc && (paddr == `CCU_REG_CMD) && !cmd_full;
    assign cmd_wdata = pwdata;

    // Result pop in the same access cycle as the read
    assign res_pop = rd_acc && (paddr == `CCU_REG_RESULT) && !res_empty;

    // Error response
    assign pslverr = (wr_acc && (paddr == `CCU_REG_CMD) && cmd_full) ||
                     (rd_acc && (paddr == `CCU_REG_RESULT) && res_empty);

    // Start request, ignored while a batch runs
    assign start_req = wr_acc && (paddr == `CCU_REG_CTRL) && pwdata[0] && !busy;

    // One-cycle start pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= 1'b0;
        end else begin
            start <= start_req;
        end
    end

    // Read mux
    always_comb begin
        prdata = '0;
        if (rd_acc) begin
            case (paddr)
                `CCU_REG_STATUS: prdata = {28'd0, res_empty, cmd_full, done, busy};
                `CCU_REG_RESULT: prdata = res_empty ? 32'd0 : res_rdata;
                default:         prdata = '0;
            endcase
        end
    end

endmodule

// File: ccu/ccu_ctrl.sv
//==========================================================================
// CCU controller
// IDLE / ISSUE / DRAIN FSM with strict in-order issue
// Lowest-index result arbiter and sticky done flag
//==========================================================================
`include "ccu_params.svh"

module ccu_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    output logic             busy,
    output logic             done,
    // Command FIFO read side
    input  ccu_pkg::cmd_t    cmd_rdata,
    input  logic             cmd_empty,
    output logic             cmd_pop,
    // Result FIFO write side
    output logic             res_push,
    output ccu_pkg::result_t res_wdata,
    input  logic             res_full,
    // PE array
    pe_bus_if.ctrl           bus
);

    ccu_pkg::ccu_state_t state;
    ccu_pkg::ccu_state_t state_nxt;
    ccu_pkg::pe_idx_t    head_pe;
    ccu_pkg::pe_idx_t    sel_idx;
    logic                sel_found;
    logic                issue_ok;
    logic                drain_done;

    //======================================================================
    // Issue path
    //======================================================================
    assign head_pe = cmd_rdata[31:30];

    // Head must wait for its own PE, keeps per-PE order
    assign issue_ok = (state == ccu_pkg::ISSUE) && !cmd_empty && !bus.busy[head_pe];

    assign bus.issue_valid = issue_ok;
    assign bus.issue_pe    = head_pe;
    assign bus.issue_len   = cmd_rdata[29:24];
    assign bus.issue_base  = cmd_rdata[15:0];
    assign cmd_pop         = issue_ok;

    // Nothing in flight and nothing waiting for the result FIFO
    assign drain_done = (bus.busy == '0) && (bus.done == '0);

    assign busy = (state != ccu_pkg::IDLE);

    //======================================================================
    // FSM
    //======================================================================
    always_comb begin
        state_nxt = state;
        case (state)
            ccu_pkg::IDLE: begin
                if (start) begin
                    state_nxt = ccu_pkg::ISSUE;
                end
            end
            ccu_pkg::ISSUE: begin
                if (cmd_empty) begin
                    state_nxt = ccu_pkg::DRAIN;
                end
            end
            ccu_pkg::DRAIN: begin
                if (drain_done) begin
                    state_nxt = ccu_pkg::IDLE;
                end
            end
            default: state_nxt = ccu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ccu_pkg::IDLE;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            // Sticky until the next batch starts
            if (start) begin
                done <= 1'b0;
            end else if (state == ccu_pkg::DRAIN && drain_done) begin
                done <= 1'b1;
            end
        end
    end

    //======================================================================
    // Result collection, runs in every state
    //======================================================================
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        // Lowest index wins
        for (int i = 0; i < `CCU_NUM_PEB; i++) begin
            if (bus.done[i] && !sel_found) begin
                sel_found = 1'b1;
                sel_idx   = ccu_pkg::pe_idx_t'(i);
            end
        end
    end

    // Ack only when the result can be stored
    always_comb begin
        bus.ack = '0;
        if (sel_found && !res_full) begin
            bus.ack[sel_idx] = 1'b1;
        end
    end

    assign res_push  = sel_found && !res_full;
    assign res_wdata = {sel_idx, bus.sum[sel_idx]};

endmodule

// File: ccu/pe_array.sv
//==========================================================================
// PE array
// Accumulating PE blocks, one term per cycle
// Each block holds done with its sum until acked
//==========================================================================
`include "ccu_params.svh"

module pe_array (
    input  logic  clk,
    input  logic  rst_n,
    pe_bus_if.pe  bus
);

    for (genvar g = 0; g < `CCU_NUM_PEB; g++) begin : g_pe
        logic          load;
        logic          busy_q;
        logic          done_q;
        ccu_pkg::len_t remain;
        ccu_pkg::sum_t acc;
        ccu_pkg::sum_t term;

        // Issue addressed to this block
        assign load = bus.issue_valid && (bus.issue_pe == ccu_pkg::pe_idx_t'(g));

        // Control state
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                busy_q <= 1'b0;
                done_q <= 1'b0;
                remain <= '0;
            end else if (load) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
                remain <= bus.issue_len;
            end else if (done_q) begin
                // Hold until the controller takes the sum
                if (bus.ack[g]) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b0;
                end
            end else if (busy_q) begin
                if (remain != '0) begin
                    remain <= remain - 1'b1;
                end
                // Last term this cycle, or empty run
                if (remain <= ccu_pkg::len_t'(1)) begin
                    done_q <= 1'b1;
                end
            end
        end

        // Datapath
        always_ff @(posedge clk) begin
            if (load) begin
                acc  <= '0;
                term <= ccu_pkg::sum_t'(bus.issue_base);
            end else if (busy_q && !done_q && remain != '0) begin
                acc  <= acc + term;
                term <= term + 1'b1;
            end
        end

        assign bus.busy[g] = busy_q;
        assign bus.done[g] = done_q;
        assign bus.sum[g]  = acc;
    end

endmodule

// File: hdl/ccu_top.sv
//==========================================================================
// CCU top level
// APB register block, command and result FIFOs, controller, PE array
//==========================================================================
`include "ccu_params.svh"

module ccu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`CCU_APB_AW-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr
);

    // Command path
    logic             cmd_push;
    logic             cmd_pop;
    logic             cmd_full;
    logic             cmd_empty;
    ccu_pkg::cmd_t    cmd_wdata;
    ccu_pkg::cmd_t    cmd_rdata;

    // Result path
    logic             res_push;
    logic             res_pop;
    logic             res_full;
    logic             res_empty;
    ccu_pkg::result_t res_wdata;
    ccu_pkg::result_t res_rdata;

    // Control
    logic             start;
    logic             busy;
    logic             done;

    pe_bus_if pe_bus ();

    apb_cfg_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cmd_push  (cmd_push),
        .cmd_wdata (cmd_wdata),
        .cmd_full  (cmd_full),
        .res_pop   (res_pop),
        .res_rdata (res_rdata),
        .res_empty (res_empty),
        .start     (start),
        .busy      (busy),
        .done      (done)
    );

    sync_fifo #(.DATA_W(32), .ADDR_W(`CCU_CMD_AW)) cmd_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (cmd_push),
        .pop   (cmd_pop),
        .din   (cmd_wdata),
        .dout  (cmd_rdata),
        .empty (cmd_empty),
        .full  (cmd_full)
    );

    sync_fifo #(.DATA_W(32), .ADDR_W(`CCU_RES_AW)) res_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (res_push),
        .pop   (res_pop),
        .din   (res_wdata),
        .dout  (res_rdata),
        .empty (res_empty),
        .full  (res_full)
    );

    ccu_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .cmd_rdata (cmd_rdata),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .res_push  (res_push),
        .res_wdata (res_wdata),
        .res_full  (res_full),
        .bus       (pe_bus.ctrl)
    );

    pe_array u_pe_array (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (pe_bus.pe)
    );

endmodule

// File: verification/ccu_tb.sv
//============================================================================
// CCU testbench
// Clock, reset, APB read and write tasks, stimulus table, LFSR commands
// Per-PE ordered result matching, value check task, cycle timeout
//============================================================================
`include "ccu_params.svh"

module ccu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // 1 + 8 table + 16 overflow + 12 random commands
    localparam int NUM_CMDS = 37;
    localparam int TIMEOUT  = 64 * NUM_CMDS + 2000;

    typedef struct packed {
        logic [1:0]  pe;
        logic [15:0] base;
        logic [5:0]  len;
        logic [29:0] sum;
    } row_t;

    // Hand-computed sums, includes an empty run and the largest run
    localparam row_t ROWS [8] = '{
        '{2'd0, 16'd1,     6'd10, 30'd55},
        '{2'd1, 16'd100,   6'd0,  30'd0},
        '{2'd2, 16'hFFFF,  6'd63, 30'd4130658},
        '{2'd3, 16'd7,     6'd1,  30'd7},
        '{2'd0, 16'd20,    6'd3,  30'd63},
        '{2'd2, 16'd5,     6'd2,  30'd11},
        '{2'd1, 16'd1000,  6'd4,  30'd4006},
        '{2'd3, 16'd0,     6'd63, 30'd1953}
    };

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr;
    logic [31:0] expected [$];
    int          cycles = 0;

    ccu_top DUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #4 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: no completion within %0d cycles", TIMEOUT);
            $display("sim failed");
            $fatal(1);
        end
    end

    //========================================================================
    // Helpers
    //========================================================================
    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Galois LFSR, taps x^32+x^22+x^2+x+1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // Sum of base .. base+len-1 modulo 2^30
    function automatic logic [29:0] ref_sum(input logic [15:0] base, input logic [5:0] len);
        logic [29:0] s;
        s = '0;
        for (int k = 0; k < int'(len); k++) begin
            s = s + 30'(base) + 30'(k);
        end
        return s;
    endfunction

    // APB transfers start and end 1 ns after a rising edge
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        check_val("pready", 32'(pready), 32'd1);
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_val("pready", 32'(pready), 32'd1);
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    // Push one command and remember its result
    task automatic issue_cmd(input logic [1:0] pe, input logic [15:0] base,
                             input logic [5:0] len, input logic [29:0] sum);
        logic err;
        apb_write(`CCU_REG_CMD, {pe, len, 8'h00, base}, err);
        check_val("pslverr(cmd)", 32'(err), 32'd0);
        expected.push_back({pe, sum});
    endtask

    task automatic start_batch();
        logic err;
        apb_write(`CCU_REG_CTRL, 32'h1, err);
        check_val("pslverr(ctrl)", 32'(err), 32'd0);
    endtask

    // Same PE field, oldest entry first
    task automatic match_result(input logic [31:0] got);
        int idx;
        idx = -1;
        for (int i = 0; i < expected.size(); i++) begin
            if (idx < 0 && expected[i][31:30] == got[31:30]) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            $display("unexpected result 0x%08h with no pending command", got);
            $display("sim failed");
            $fatal(1);
        end
        check_val("prdata(result)", got, expected[idx]);
        expected.delete(idx);
    endtask

    // Pop results until the batch is done and the result FIFO is empty
    task automatic collect_results();
        logic [31:0] st;
        logic [31:0] res;
        logic        err;
        st = '0;
        while (!(st[1] && !st[0] && st[3])) begin
            apb_read(`CCU_REG_STATUS, st, err);
            if (!st[3]) begin
                apb_read(`CCU_REG_RESULT, res, err);
                check_val("pslverr(result)", 32'(err), 32'd0);
                match_result(res);
            end
        end
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        st = '0;
        while (!(st[1] && !st[0])) begin
            apb_read(`CCU_REG_STATUS, st, err);
        end
    endtask

    // Batch finished, nothing left over
    task automatic check_drained();
        logic [31:0] st;
        logic        err;
        apb_read(`CCU_REG_STATUS, st, err);
        check_val("status", st, 32'h0000000A);
        check_val("pending results", 32'(expected.size()), 32'd0);
    endtask

    //========================================================================
    // Test sequence
    //========================================================================
    initial begin
        logic [31:0] rd;
        logic        err;
        logic [1:0]  r_pe;
        logic [15:0] r_base;
        logic [5:0]  r_len;
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        lfsr    = 32'h4116;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        @(posedge clk);
        #1;

        // After reset
        apb_read(`CCU_REG_STATUS, rd, err);
        check_val("status", rd, 32'h00000008);
        apb_read(`CCU_REG_RESULT, rd, err);
        check_val("pslverr(empty read)", 32'(err), 32'd1);
        check_val("prdata(empty read)", rd, 32'd0);

        // Single command, PE 2 sums 10..14
        issue_cmd(2'd2, 16'd10, 6'd5, 30'd60);
        start_batch();
        wait_done();
        apb_read(`CCU_REG_RESULT, rd, err);
        check_val("prdata(result)", rd, {2'd2, 30'd60});
        void'(expected.pop_front());
        check_drained();

        // Table batch over all PEs
        foreach (ROWS[i]) begin
            issue_cmd(ROWS[i].pe, ROWS[i].base, ROWS[i].len, ROWS[i].sum);
        end
        start_batch();
        collect_results();
        check_drained();

        // Command FIFO overflow, 17th write dropped
        for (int i = 0; i < 16; i++) begin
            issue_cmd(2'(i), 16'(100 * i), 6'd3, ref_sum(16'(100 * i), 6'd3));
        end
        apb_write(`CCU_REG_CMD, {2'd0, 6'd1, 8'h00, 16'hABCD}, err);
        check_val("pslverr(overflow)", 32'(err), 32'd1);
        apb_read(`CCU_REG_STATUS, rd, err);
        check_val("status.cmd_full", 32'(rd[2]), 32'd1);
        start_batch();
        // Host stays away from RESULT, results pile up and PEs stall
        repeat (40) begin
            apb_read(`CCU_REG_STATUS, rd, err);
        end
        check_val("status(stalled)", rd, 32'h00000001);
        collect_results();
        check_drained();

        // Random batch, done clears on start, second start ignored
        for (int i = 0; i < 12; i++) begin
            r_pe   = 2'(rand_bits(2));
            r_base = 16'(rand_bits(16));
            r_len  = 6'(rand_bits(6));
            issue_cmd(r_pe, r_base, r_len, ref_sum(r_base, r_len));
        end
        start_batch();
        apb_read(`CCU_REG_STATUS, rd, err);
        check_val("status.busy", 32'(rd[0]), 32'd1);
        check_val("status.done", 32'(rd[1]), 32'd0);
        start_batch();
        collect_results();
        check_drained();
        apb_read(`CCU_REG_RESULT, rd, err);
        check_val("pslverr(extra result)", 32'(err), 32'd1);

        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/ccu_pkg.sv
common/pe_bus_if.sv
hdl/sync_fifo.sv
hdl/apb_cfg_regs.sv
ccu/ccu_ctrl.sv
ccu/pe_array.sv
hdl/ccu_top.sv
verification/ccu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CCU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module ccu_tb -o ccu_sim

./obj_dir/ccu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
else
    exit 1
fi
